/* hw/avr_types_pkg.sv */
package avr_types_pkg;

    // Basic widths of the core
    typedef logic [7:0]  data_t;     // Register or memory byte
    typedef logic [15:0] addr_t;     // Program or data address
    typedef logic [15:0] instr_t;    // One opcode word
    typedef logic [4:0]  reg_idx_t;  // R0 to R31

    // Status register, bit 7 down to bit 0
    typedef struct packed {
        logic i;    // Global interrupt enable
        logic t;    // Bit copy storage
        logic h;    // Half carry
        logic s;    // Sign flag (n xor v)
        logic v;    // Two's complement overflow
        logic n;    // Negative
        logic z;    // Zero
        logic c;    // Carry
    } sreg_t;

    // X pointer lives in R27:R26
    localparam reg_idx_t X_LO_IDX = 5'd26;
    localparam reg_idx_t X_HI_IDX = 5'd27;

endpackage

/* hw/avr_isa_pkg.sv */
package avr_isa_pkg;

    // ----------------------------------------
    // ALU operations
    // ----------------------------------------
    typedef enum logic [4:0] {
        PASS,   // Second operand straight through (LDI, MOV)
        ADD,
        ADC,
        SUB,    // Also CP, CPI, SUBI
        SBC,    // Also CPC, SBCI
        AND,
        EOR,
        OR,
        COM,    // Ones complement
        NEG,    // Twos complement
        SWAP,   // Nibble exchange
        INC,
        DEC,
        LSR,
        ASR,
        ROR     // Through carry
    } alu_op_e;

    // ----------------------------------------
    // Instruction classes seen by the core
    // ----------------------------------------
    typedef enum logic [2:0] {
        NOP,
        ALU,        // Register result and SREG
        BRANCH,     // BRBS and BRBC
        RJMP,
        LD,         // Two cycles
        ST,
        ILLEGAL     // Executed as NOP
    } op_class_e;

endpackage

/* hw/avr_decoder.sv */
module avr_decoder (
    input  avr_types_pkg::instr_t   instr_i,
    output avr_isa_pkg::op_class_e  op_class_o,
    output avr_isa_pkg::alu_op_e    alu_op_o,
    output avr_types_pkg::reg_idx_t rd_o,
    output avr_types_pkg::reg_idx_t rr_o,
    output avr_types_pkg::data_t    imm_o,
    output logic                    use_imm_o,
    output logic                    write_rd_o,
    output logic                    write_sreg_o,
    output avr_types_pkg::addr_t    offset_o,
    output logic [2:0]              branch_bit_o,
    output logic                    branch_set_o,
    output logic                    post_inc_o
);

    import avr_isa_pkg::*;

    // Fixed fields, meaningful only for the classes that use them
    assign imm_o        = {instr_i[11:8], instr_i[3:0]};
    assign rr_o         = {instr_i[9], instr_i[3:0]};
    assign branch_bit_o = instr_i[2:0];
    assign branch_set_o = ~instr_i[10];    // BRBS has bit 10 clear
    assign post_inc_o   = instr_i[0];      // X+ form

    always_comb begin
        op_class_o   = ILLEGAL;
        alu_op_o     = PASS;
        rd_o         = instr_i[8:4];
        use_imm_o    = 1'b0;
        write_rd_o   = 1'b0;
        write_sreg_o = 1'b0;
        offset_o     = {{9{instr_i[9]}}, instr_i[9:3]};   // Branch k

        casez (instr_i)
            16'b0000_0000_0000_0000: op_class_o = NOP;

            // Immediate group, Rd only from R16 up
            16'b0011_????_????_????,
            16'b01??_????_????_????: begin
                op_class_o   = ALU;
                rd_o         = {1'b1, instr_i[7:4]};
                use_imm_o    = 1'b1;
                write_rd_o   = instr_i[15:12] != 4'b0011;  // CPI only compares
                write_sreg_o = 1'b1;
                case (instr_i[14:12])
                    3'b100:  alu_op_o = SBC;
                    3'b110:  alu_op_o = OR;
                    3'b111:  alu_op_o = AND;
                    default: alu_op_o = SUB;    // CPI, SUBI
                endcase
            end

            // Two-register group
            16'b00??_????_????_????: begin
                op_class_o   = ALU;
                write_rd_o   = (instr_i[13:10] != 4'b0001) && (instr_i[13:10] != 4'b0101);
                write_sreg_o = instr_i[13:10] != 4'b1011;  // MOV keeps flags
                case (instr_i[13:10])
                    4'b0001, 4'b0010: alu_op_o = SBC;    // CPC, SBC
                    4'b0011: alu_op_o = ADD;
                    4'b0101, 4'b0110: alu_op_o = SUB;    // CP, SUB
                    4'b0111: alu_op_o = ADC;
                    4'b1000: alu_op_o = AND;
                    4'b1001: alu_op_o = EOR;
                    4'b1010: alu_op_o = OR;
                    4'b1011: alu_op_o = PASS;
                    default: op_class_o = ILLEGAL;       // MOVW, CPSE
                endcase
            end

            16'b1110_????_????_????: begin      // LDI
                op_class_o = ALU;
                rd_o       = {1'b1, instr_i[7:4]};
                use_imm_o  = 1'b1;
                write_rd_o = 1'b1;
            end

            16'b1100_????_????_????: begin
                op_class_o = RJMP;
                offset_o   = {{4{instr_i[11]}}, instr_i[11:0]};
            end

            16'b1111_0???_????_????: op_class_o = BRANCH;
            16'b1001_000?_????_110?: op_class_o = LD;
            16'b1001_001?_????_110?: op_class_o = ST;

            // Single-operand group
            16'b1001_010?_????_????: begin
                op_class_o   = ALU;
                write_rd_o   = 1'b1;
                write_sreg_o = 1'b1;
                case (instr_i[3:0])
                    4'b0000: alu_op_o = COM;
                    4'b0001: alu_op_o = NEG;
                    4'b0010: alu_op_o = SWAP;
                    4'b0011: alu_op_o = INC;
                    4'b0101: alu_op_o = ASR;
                    4'b0110: alu_op_o = LSR;
                    4'b0111: alu_op_o = ROR;
                    4'b1010: alu_op_o = DEC;
                    default: op_class_o = ILLEGAL;
                endcase
            end

            default: op_class_o = ILLEGAL;
        endcase
    end

endmodule

/* hw/avr_regfile.sv */
module avr_regfile (
    input  logic                    clock,
    input  logic                    reset_i,
    input  avr_types_pkg::reg_idx_t rd_idx_i,
    input  avr_types_pkg::reg_idx_t rr_idx_i,
    input  logic                    we_i,
    input  avr_types_pkg::reg_idx_t wr_idx_i,
    input  avr_types_pkg::data_t    wr_data_i,
    input  logic                    x_we_i,
    input  avr_types_pkg::addr_t    x_data_i,
    output avr_types_pkg::data_t    rd_data_o,
    output avr_types_pkg::data_t    rr_data_o,
    output avr_types_pkg::addr_t    x_o
);

    import avr_types_pkg::*;

    data_t regs [32];   // R0 to R31

    assign rd_data_o = regs[rd_idx_i];
    assign rr_data_o = regs[rr_idx_i];
    assign x_o       = {regs[X_HI_IDX], regs[X_LO_IDX]};

    always_ff @(posedge clock) begin
        if (reset_i) begin
            regs <= '{default: '0};
        end else begin
            if (we_i) regs[wr_idx_i] <= wr_data_i;
            if (x_we_i) begin                   // Pointer post-increment
                regs[X_LO_IDX] <= x_data_i[7:0];
                regs[X_HI_IDX] <= x_data_i[15:8];
            end
        end
    end

    // Core never schedules a byte write onto the X pair during a pointer update
    assert property (@(posedge clock) disable iff (reset_i)
        !(we_i && x_we_i && (wr_idx_i == X_LO_IDX || wr_idx_i == X_HI_IDX)))
        else $error("byte write and X write collide on R26/R27");

endmodule

/* hw/avr_alu.sv */
module avr_alu (
    input  avr_isa_pkg::alu_op_e  op_i,
    input  avr_types_pkg::data_t  a_i,      // Rd
    input  avr_types_pkg::data_t  b_i,      // Rr or K
    input  avr_types_pkg::sreg_t  sreg_i,
    output avr_types_pkg::data_t  result_o,
    output avr_types_pkg::sreg_t  sreg_o
);

    import avr_types_pkg::*;
    import avr_isa_pkg::*;

    logic [8:0] sum9;
    logic [8:0] diff9;
    logic       carry_in;
    logic       add_v;
    logic       sub_v;
    logic       add_h;
    logic       sub_h;
    data_t      res;
    sreg_t      flags;

    // ----------------------------------------
    // Adder and subtractor
    // ----------------------------------------
    assign carry_in = (op_i == ADC || op_i == SBC) ? sreg_i.c : 1'b0;
    assign sum9     = {1'b0, a_i} + {1'b0, b_i} + {8'd0, carry_in};
    assign diff9    = {1'b0, a_i} - {1'b0, b_i} - {8'd0, carry_in};

    // Overflow from the sign bits
    assign add_v = (a_i[7] & b_i[7] & ~sum9[7]) | (~a_i[7] & ~b_i[7] & sum9[7]);
    assign sub_v = (a_i[7] & ~b_i[7] & ~diff9[7]) | (~a_i[7] & b_i[7] & diff9[7]);

    // Borrow or carry out of bit 3
    assign add_h = (a_i[3] & b_i[3]) | (b_i[3] & ~sum9[3]) | (~sum9[3] & a_i[3]);
    assign sub_h = (~a_i[3] & b_i[3]) | (b_i[3] & diff9[3]) | (diff9[3] & ~a_i[3]);

    // ----------------------------------------
    // Result and flags per operation
    // ----------------------------------------
    always_comb begin
        res   = b_i;
        flags = sreg_i;

        case (op_i)
            PASS: res = b_i;
            ADD, ADC: begin
                res     = sum9[7:0];
                flags.h = add_h;
                flags.v = add_v;
                flags.c = sum9[8];
            end
            SUB, SBC: begin
                res     = diff9[7:0];
                flags.h = sub_h;
                flags.v = sub_v;
                flags.c = diff9[8];     // Borrow
            end
            AND: res = a_i & b_i;
            EOR: res = a_i ^ b_i;
            OR:  res = a_i | b_i;
            COM: begin
                res     = ~a_i;
                flags.c = 1'b1;
            end
            NEG: begin
                res     = 8'd0 - a_i;
                flags.h = res[3] | a_i[3];
                flags.v = res == 8'h80;
                flags.c = a_i != 8'd0;
            end
            SWAP: res = {a_i[3:0], a_i[7:4]};
            INC: begin
                res     = a_i + 8'd1;
                flags.v = res == 8'h80;
            end
            DEC: begin
                res     = a_i - 8'd1;
                flags.v = res == 8'h7F;
            end
            LSR, ASR, ROR: begin
                case (op_i)
                    LSR:     res = {1'b0, a_i[7:1]};
                    ASR:     res = {a_i[7], a_i[7:1]};
                    default: res = {sreg_i.c, a_i[7:1]};
                endcase
                flags.c = a_i[0];
                flags.v = res[7] ^ a_i[0];      // n xor c after the shift
            end
            default: res = 8'h00;
        endcase

        // Logic group clears V
        if (op_i == AND || op_i == EOR || op_i == OR || op_i == COM) flags.v = 1'b0;

        // Common N, Z, S except where SREG stays put
        if (op_i != PASS && op_i != SWAP) begin
            flags.n = res[7];
            flags.z = (res == 8'h00) && (op_i != SBC || sreg_i.z);   // SBC chains Z
            flags.s = flags.n ^ flags.v;
        end
    end

    assign result_o = res;
    assign sreg_o   = flags;

    // Decoder always resolves to a defined operation
    always_comb begin
        assert (!$isunknown(op_i)) else $error("ALU operation is unknown");
    end

endmodule

/* hw/avr_core.sv */
module avr_core (
    input  logic                   clock,
    input  logic                   reset_i,
    // Program memory
    output avr_types_pkg::addr_t   pc_o,
    input  avr_types_pkg::instr_t  instr_i,     // Word at pc_o
    // Data memory
    output avr_types_pkg::addr_t   address_o,
    input  avr_types_pkg::data_t   data_i,      // Byte at address_o
    output avr_types_pkg::data_t   data_o,
    output logic                   wren_o
);

    import avr_types_pkg::*;
    import avr_isa_pkg::*;

    op_class_e  op_class;
    alu_op_e    alu_op;
    reg_idx_t   rd_idx;
    reg_idx_t   rr_idx;
    data_t      imm;
    data_t      rd_data;
    data_t      rr_data;
    data_t      alu_b;
    data_t      alu_result;
    data_t      wb_data;
    logic       use_imm;
    logic       write_rd;
    logic       write_sreg;
    logic       branch_set;
    logic       post_inc;
    logic [2:0] branch_bit;
    addr_t      offset;
    addr_t      x_ptr;
    addr_t      pc_inc;
    sreg_t      sreg_q;
    sreg_t      sreg_next;
    logic [7:0] sreg_bits;
    logic       ld_phase_q;     // Second cycle of LD
    logic       rf_we;
    logic       x_we;
    logic       branch_taken;

    avr_decoder decoder_i (
        .instr_i      (instr_i),
        .op_class_o   (op_class),
        .alu_op_o     (alu_op),
        .rd_o         (rd_idx),
        .rr_o         (rr_idx),
        .imm_o        (imm),
        .use_imm_o    (use_imm),
        .write_rd_o   (write_rd),
        .write_sreg_o (write_sreg),
        .offset_o     (offset),
        .branch_bit_o (branch_bit),
        .branch_set_o (branch_set),
        .post_inc_o   (post_inc)
    );

    // ----------------------------------------
    // Write-back and pointer control
    // ----------------------------------------
    assign rf_we   = (op_class == ALU && write_rd) || (op_class == LD && ld_phase_q);
    assign wb_data = ld_phase_q ? data_i : alu_result;
    assign x_we    = post_inc && (op_class == ST || (op_class == LD && !ld_phase_q));
    assign alu_b   = use_imm ? imm : rr_data;

    avr_regfile regfile_i (
        .clock     (clock),
        .reset_i   (reset_i),
        .rd_idx_i  (rd_idx),
        .rr_idx_i  (rr_idx),
        .we_i      (rf_we),
        .wr_idx_i  (rd_idx),
        .wr_data_i (wb_data),
        .x_we_i    (x_we),
        .x_data_i  (x_ptr + 16'd1),
        .rd_data_o (rd_data),
        .rr_data_o (rr_data),
        .x_o       (x_ptr)
    );

    avr_alu alu_i (
        .op_i     (alu_op),
        .a_i      (rd_data),
        .b_i      (alu_b),
        .sreg_i   (sreg_q),
        .result_o (alu_result),
        .sreg_o   (sreg_next)
    );

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------
    assign pc_inc       = pc_o + 16'd1;
    assign sreg_bits    = sreg_q;
    assign branch_taken = sreg_bits[branch_bit] == branch_set;

    always_ff @(posedge clock) begin
        if (reset_i) begin
            pc_o       <= '0;
            ld_phase_q <= 1'b0;
            sreg_q     <= '0;
            address_o  <= '0;
            data_o     <= '0;
            wren_o     <= 1'b0;
        end else begin
            wren_o <= 1'b0;     // Store strobe lasts one cycle
            case (op_class)
                RJMP:   pc_o <= pc_inc + offset;
                BRANCH: pc_o <= branch_taken ? pc_inc + offset : pc_inc;
                LD: begin
                    if (ld_phase_q) pc_o <= pc_inc;
                    else address_o <= x_ptr;    // PC holds for the data phase
                    ld_phase_q <= ~ld_phase_q;
                end
                ST: begin
                    address_o <= x_ptr;
                    data_o    <= rd_data;
                    wren_o    <= 1'b1;
                    pc_o      <= pc_inc;
                end
                default: pc_o <= pc_inc;        // NOP, ALU, illegal
            endcase
            if (op_class == ALU && write_sreg) sreg_q <= sreg_next;
        end
    end

    // A store strobe never lands in the middle of a load
    assert property (@(posedge clock) disable iff (reset_i) ld_phase_q |-> !wren_o)
        else $error("wren_o high during LD data phase");

endmodule

/* test/avr_tb_mem.sv */
module avr_tb_mem (
    input  logic        clock,
    input  logic        reset_i,
    input  logic [7:0]  a_i,            // First random operand
    input  logic [7:0]  b_i,            // Second random operand
    input  logic [15:0] pc_i,
    output logic [15:0] instr_o,
    input  logic [15:0] address_i,
    input  logic [7:0]  wdata_i,
    input  logic        wren_i,
    output logic [7:0]  rdata_o,
    output logic [7:0]  write_count_o   // Stores seen since reset
);

    timeunit 1ns;
    timeprecision 1ps;

    // Register roles in the program
    localparam logic [4:0] R_A    = 5'd16;
    localparam logic [4:0] R_B    = 5'd17;
    localparam logic [4:0] R_T    = 5'd18;   // Scratch result
    localparam logic [4:0] R_HIT  = 5'd20;
    localparam logic [4:0] R_MISS = 5'd21;
    localparam logic [4:0] R_LD   = 5'd22;
    localparam logic [4:0] R_XL   = 5'd26;
    localparam logic [4:0] R_XH   = 5'd27;

    localparam logic [7:0] MARK_HIT  = 8'hA5;
    localparam logic [7:0] MARK_MISS = 8'h5A;
    localparam logic [7:0] X_REWIND  = 8'hF7;   // 0 - 0xF7 leaves X at 9

    // Two-register opcode prefixes, bits 15 to 10
    localparam logic [5:0] OP_ADD = 6'b000011;
    localparam logic [5:0] OP_SUB = 6'b000110;
    localparam logic [5:0] OP_CP  = 6'b000101;
    localparam logic [5:0] OP_AND = 6'b001000;
    localparam logic [5:0] OP_EOR = 6'b001001;
    localparam logic [5:0] OP_MOV = 6'b001011;

    logic [7:0] ram [65536];

    function automatic logic [15:0] ldi(input logic [4:0] d, input logic [7:0] k);
        return {4'b1110, k[7:4], d[3:0], k[3:0]};
    endfunction

    function automatic logic [15:0] two_reg(input logic [5:0] op, input logic [4:0] d,
                                            input logic [4:0] r);
        return {op, r[4], d, r[3:0]};
    endfunction

    function automatic logic [15:0] one_reg(input logic [4:0] d, input logic [3:0] code);
        return {7'b1001_010, d, code};
    endfunction

    function automatic logic [15:0] st_x_inc(input logic [4:0] r);
        return {7'b1001_001, r, 4'b1101};
    endfunction

    // Operation n of the ALU section, always R18 against R17
    function automatic logic [15:0] alu_step(input int n);
        case (n)
            0:       return two_reg(OP_ADD, R_T, R_B);
            1:       return two_reg(OP_SUB, R_T, R_B);
            2:       return two_reg(OP_AND, R_T, R_B);
            3:       return two_reg(OP_EOR, R_T, R_B);
            4:       return one_reg(R_T, 4'b0000);     // COM
            5:       return one_reg(R_T, 4'b0010);     // SWAP
            default: return one_reg(R_T, 4'b0110);     // LSR
        endcase
    endfunction

    function automatic logic [15:0] word_at(input logic [15:0] pc, input logic [7:0] a,
                                            input logic [7:0] b);
        int n;
        n = int'(pc);
        // Words 6 to 26 hold seven MOV, op, ST X+ triples
        if (n >= 6 && n <= 26) begin
            case ((n - 6) % 3)
                0:       return two_reg(OP_MOV, R_T, R_A);
                1:       return alu_step((n - 6) / 3);
                default: return st_x_inc(R_T);
            endcase
        end
        case (n)
            0:       return ldi(R_A, a);
            1:       return ldi(R_B, b);
            2:       return ldi(R_XL, 8'h00);
            3:       return ldi(R_XH, 8'h00);
            4:       return ldi(R_HIT, MARK_HIT);
            5:       return ldi(R_MISS, MARK_MISS);
            27:      return two_reg(OP_CP, R_A, R_B);
            28:      return {6'b111100, 7'd2, 3'd1};    // BRBS Z
            29:      return st_x_inc(R_MISS);
            30:      return {4'b1100, 12'd1};
            31:      return st_x_inc(R_HIT);
            32:      return {6'b111100, 7'd2, 3'd0};    // BRBS C
            33:      return st_x_inc(R_MISS);
            34:      return {4'b1100, 12'd1};
            35:      return st_x_inc(R_HIT);
            36:      return ldi(R_XL, 8'h00);
            37:      return {7'b1001_000, R_LD, 4'b1100};       // LD R22, X
            38:      return {4'b0101, X_REWIND[7:4], R_XL[3:0], X_REWIND[3:0]};
            39:      return st_x_inc(R_LD);
            40:      return {4'b1100, 12'hFFF};         // Jump to itself
            default: return 16'h0000;
        endcase
    endfunction

    function automatic logic [7:0] fill_byte(input logic [15:0] addr);
        return addr[15:8] ^ {addr[6:0], addr[7]} ^ 8'h6B;
    endfunction

    assign instr_o = word_at(pc_i, a_i, b_i);
    assign rdata_o = ram[address_i];

    initial begin
        for (int i = 0; i < 65536; i++) begin
            ram[i] = fill_byte(i[15:0]);
        end
    end

    always @(posedge clock) begin
        if (reset_i) begin
            write_count_o <= 8'd0;
        end else if (wren_i) begin
            ram[address_i] <= wdata_i;
            write_count_o  <= write_count_o + 8'd1;
        end
    end

endmodule

/* test/avr_tb.sv */
module avr_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [15:0] FINAL_PC     = 16'd40;   // Address of the closing RJMP
    localparam logic [7:0]  WRITES       = 8'd10;
    localparam logic [7:0]  MARK_HIT     = 8'hA5;
    localparam logic [7:0]  MARK_MISS    = 8'h5A;
    localparam int          RESET_CYCLES = 10;
    localparam int          RUN_LIMIT    = 200;
    localparam int          HOLD_CYCLES  = 8;
    localparam int          DRIVE_DELAY  = 5;

    logic        clock = 1'b0;
    logic        reset_i;
    logic [15:0] pc;
    logic [15:0] instr;
    logic [15:0] address;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        wren;
    logic [7:0]  write_count;
    logic [15:0] last_address;
    logic [7:0]  a_byte;
    logic [7:0]  b_byte;
    logic [7:0]  expected [16];     // Store n carries expected[n]
    logic [31:0] rnd;
    int          cycle;

    always #20 clock = ~clock;

    avr_core avr_core_i (
        .clock     (clock),
        .reset_i   (reset_i),
        .pc_o      (pc),
        .instr_i   (instr),
        .address_o (address),
        .data_i    (rdata),
        .data_o    (wdata),
        .wren_o    (wren)
    );

    avr_tb_mem mem_i (
        .clock         (clock),
        .reset_i       (reset_i),
        .a_i           (a_byte),
        .b_i           (b_byte),
        .pc_i          (pc),
        .instr_o       (instr),
        .address_i     (address),
        .wdata_i       (wdata),
        .wren_i        (wren),
        .rdata_o       (rdata),
        .write_count_o (write_count)
    );

    always @(posedge clock) begin
        if (wren) last_address <= address;
    end

    task automatic report_mismatch(input string what);
        $display("** FAIL **");
        $display("mismatch at %0d ns: %s", $time, what);
        $fatal(1, "check failed");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("** FAIL **");
        $fatal(1, {"timeout: ", what});
    endtask

    // Results of the ALU section, then the branch markers and the reloaded byte
    task automatic compute_expected();
        for (int i = 0; i < 16; i++) begin
            expected[i] = 8'h00;
        end
        expected[0] = a_byte + b_byte;
        expected[1] = a_byte - b_byte;
        expected[2] = a_byte & b_byte;
        expected[3] = a_byte ^ b_byte;
        expected[4] = ~a_byte;
        expected[5] = {a_byte[3:0], a_byte[7:4]};
        expected[6] = a_byte >> 1;
        expected[7] = (a_byte == b_byte) ? MARK_HIT : MARK_MISS;   // Z after CP
        expected[8] = (a_byte < b_byte) ? MARK_HIT : MARK_MISS;    // C after CP
        expected[9] = expected[0];
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    assert property (@(posedge clock) $past(reset_i) |-> (!wren && pc == 16'd0))
        else report_mismatch("wren_o or pc_o not zero in reset");

    assert property (@(posedge clock) disable iff (reset_i) wren |-> write_count < WRITES)
        else report_mismatch("store strobe beyond the expected stores");

    assert property (@(posedge clock) disable iff (reset_i)
        (wren && write_count < WRITES) |-> address == {8'd0, write_count})
        else report_mismatch("store address differs from the store index");

    assert property (@(posedge clock) disable iff (reset_i)
        (wren && write_count < WRITES) |-> wdata == expected[write_count[3:0]])
        else report_mismatch("stored byte differs from the expected result");

    assert property (@(posedge clock) disable iff (reset_i)
        (wren && write_count != 8'd0) |-> address == last_address + 16'd1)
        else report_mismatch("store address does not follow X+");

    assert property (@(posedge clock) disable iff (reset_i) pc == FINAL_PC |=> pc == FINAL_PC)
        else report_mismatch("pc_o left the final RJMP");

    assert property (@(posedge clock) disable iff (reset_i)
        pc == FINAL_PC |=> write_count == WRITES)
        else report_mismatch("final RJMP reached with stores missing");

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        reset_i      = 1'b1;
        last_address = 16'd0;
        rnd          = $urandom(32'he6f1_5c05);
        a_byte       = rnd[7:0];
        rnd          = $urandom();
        b_byte       = rnd[7:0];
        compute_expected();

        for (cycle = 0; cycle < RESET_CYCLES; cycle++) begin
            @(posedge clock);
        end
        #(DRIVE_DELAY) reset_i = 1'b0;

        // Program end is the RJMP with all ten stores done
        cycle = 0;
        while (!(pc == FINAL_PC && write_count == WRITES) && cycle < RUN_LIMIT) begin
            @(posedge clock);
            #(DRIVE_DELAY);
            cycle++;
        end

        if (pc == FINAL_PC && write_count == WRITES) begin
            for (cycle = 0; cycle < HOLD_CYCLES; cycle++) begin
                @(posedge clock);
            end
            $display("** PASS **");
            $finish;
        end else begin
            abort_on_timeout("final RJMP not reached with all stores seen");
        end
    end

endmodule

/* files.f */
hw/avr_types_pkg.sv
hw/avr_isa_pkg.sv
hw/avr_decoder.sv
hw/avr_regfile.sv
hw/avr_alu.sv
hw/avr_core.sv
test/avr_tb_mem.sv
test/avr_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --assert --timing --timescale 1ns/1ps
TOP       := avr_tb
FILELIST  := files.f
BUILD_DIR := obj_dir

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
